// ==== build.f ====
dram_pkg.sv
dram_apb_port.sv
dram_cmd_fsm.sv
dram_delay_timer.sv
dram_refresh_timer.sv
dram_row_table.sv
dram_ctrl_top.sv
tb_dram_model.sv
tb_dram_ctrl.sv

// ==== Bender.yml ====
package:
  name: dram_ctrl

sources:
  - dram_pkg.sv
  - dram_apb_port.sv
  - dram_cmd_fsm.sv
  - dram_delay_timer.sv
  - dram_refresh_timer.sv
  - dram_row_table.sv
  - dram_ctrl_top.sv
  - target: test
    files:
      - tb_dram_model.sv
      - tb_dram_ctrl.sv

// ==== tb_dram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dram_ctrl;
    import dram_pkg::*;

    localparam int KIND_WR  = 0;
    localparam int KIND_RD  = 1;
    localparam int KIND_ERR = 2;
    localparam int NUM_ENTRIES = 10;
    localparam int ACCESS_LIMIT = 200;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [3:0]  act;
        logic [3:0]  pre;
        logic [3:0]  prea;
    } entry_t;

    logic                CLK;
    logic                nRST;
    logic                PSEL;
    logic                PENABLE;
    logic                PWRITE;
    logic [31:0]         PADDR;
    logic [DATA_W-1:0]   PWDATA;
    logic [DATA_W-1:0]   PRDATA;
    logic                PREADY;
    logic                PSLVERR;
    dram_cmd_t           dram_cmd;
    logic [DATA_W-1:0]   dram_rdata;

    entry_t              table_q [NUM_ENTRIES];
    logic [DATA_W-1:0]   sb [0:65535];
    logic [15:0]         written [$];
    logic [31:0]         lcg_state;

    dram_ctrl_top dram_ctrl_top_inst (
        .CLK(CLK), .nRST(nRST),
        .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA),
        .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
        .dram_cmd(dram_cmd), .dram_rdata(dram_rdata)
    );

    tb_dram_model tb_dram_model_inst (
        .CLK(CLK), .nRST(nRST), .dram_cmd(dram_cmd), .dram_rdata(dram_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] word_addr(int bank, int row, int col);
        dram_addr_t a;
        a.bank = bank[1:0];
        a.row  = row[7:0];
        a.col  = col[5:0];
        return {14'b0, a, 2'b00};
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input dram_op_t op, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s count got 0x%h expected 0x%h", op.name(), got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // One APB transfer with setup and then access until PREADY.
    task automatic apb_xfer(input logic we, input logic [31:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = we;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge CLK);
        PENABLE = 1'b1;
        forever begin
            @(posedge CLK);
            if (PREADY) break;
            cycles++;
            if (cycles > ACCESS_LIMIT) fail_now("Timeout waiting for PREADY.");
        end
        rdata = PRDATA;
        err   = PSLVERR;
        @(negedge CLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [DATA_W-1:0] wdata,
                             output logic err);
        logic [DATA_W-1:0] unused;
        apb_xfer(1'b1, addr, wdata, unused, err);
        if (!err) sb[addr[17:2]] = wdata;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic err);
        logic [DATA_W-1:0] data;
        apb_xfer(1'b0, addr, '0, data, err);
        if (!err) check_data("PRDATA", data, sb[addr[17:2]]);
    endtask

    // An access right after a REF must open its row again.
    task automatic random_access(input logic we, input logic [31:0] addr);
        logic need_act;
        int   act0;
        logic err;
        need_act = tb_dram_model_inst.ref_no_act;
        act0     = tb_dram_model_inst.act_cnt;
        if (we) apb_write(addr, lcg_next(), err);
        else apb_read(addr, err);
        check_flag("PSLVERR", err, 1'b0);
        if (need_act) check_count(ACT, (tb_dram_model_inst.act_cnt > act0) ? 1 : 0, 1);
    endtask

    initial begin
        int   act0, pre0, prea0, ref0, cmd0, cycles;
        int   bank, row, col;
        logic err;
        logic [31:0] addr;
        lcg_state = 32'd39;
        nRST    = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;

        table_q[0] = '{KIND_WR,  word_addr(0, 5, 1), 1, 0, 0};
        table_q[1] = '{KIND_RD,  word_addr(0, 5, 1), 0, 0, 0}; // Hit.
        table_q[2] = '{KIND_WR,  word_addr(0, 5, 2), 0, 0, 0};
        table_q[3] = '{KIND_WR,  word_addr(1, 9, 0), 1, 0, 0}; // New bank.
        table_q[4] = '{KIND_RD,  word_addr(0, 5, 2), 0, 0, 0};
        table_q[5] = '{KIND_WR,  word_addr(0, 7, 3), 1, 1, 0}; // Conflict.
        table_q[6] = '{KIND_RD,  word_addr(0, 7, 3), 0, 0, 0};
        table_q[7] = '{KIND_RD,  word_addr(1, 9, 0), 0, 0, 0};
        table_q[8] = '{KIND_ERR, 32'h0004_0000,      0, 0, 0};
        table_q[9] = '{KIND_RD,  word_addr(0, 5, 1), 1, 1, 0};

        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // Nothing completes or issues during the power-up wait.
        repeat (T_INIT + 4) begin
            @(posedge CLK);
            check_flag("PREADY", PREADY, 1'b0);
            check_flag("PSLVERR", PSLVERR, 1'b0);
        end
        check_count(NOP, tb_dram_model_inst.cmd_cnt, 0);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            act0  = tb_dram_model_inst.act_cnt;
            pre0  = tb_dram_model_inst.pre_cnt;
            prea0 = tb_dram_model_inst.prea_cnt;
            ref0  = tb_dram_model_inst.ref_cnt;
            cmd0  = tb_dram_model_inst.cmd_cnt;
            case (table_q[i].kind)
                KIND_WR: apb_write(table_q[i].addr, lcg_next(), err);
                KIND_RD: apb_read(table_q[i].addr, err);
                default: apb_read(table_q[i].addr, err);
            endcase
            check_flag("PSLVERR", err, table_q[i].kind == KIND_ERR);
            if (table_q[i].kind == KIND_ERR) begin
                check_count(NOP, tb_dram_model_inst.cmd_cnt - cmd0, 0);
            end
            // A refresh inside the access changes the row state, so counts are skipped.
            if (tb_dram_model_inst.ref_cnt == ref0) begin
                check_count(ACT, tb_dram_model_inst.act_cnt - act0, table_q[i].act);
                check_count(PRE, tb_dram_model_inst.pre_cnt - pre0, table_q[i].pre);
                check_count(PREA, tb_dram_model_inst.prea_cnt - prea0, table_q[i].prea);
            end
        end

        for (int i = 0; i < 40; i++) begin
            bank = (lcg_next() >> 16) % 4;
            row  = (lcg_next() >> 16) % 4;
            col  = (lcg_next() >> 16) % 64;
            addr = word_addr(bank, row, col);
            random_access(1'b1, addr);
            written.push_back(addr[17:2]);
            addr = {14'b0, written[(lcg_next() >> 16) % written.size()], 2'b00};
            random_access(1'b0, addr);
        end

        // Wait for a fresh REF past three intervals, then touch a row again.
        cycles = 0;
        ref0   = tb_dram_model_inst.ref_cnt;
        while (tb_dram_model_inst.ref_cnt < 4 || tb_dram_model_inst.ref_cnt == ref0) begin
            @(posedge CLK);
            cycles++;
            if (cycles > 4 * REF_INTERVAL) fail_now("Timeout waiting for refresh.");
        end
        random_access(1'b0, {14'b0, written[0], 2'b00});

        check_count(REF, tb_dram_model_inst.ref_bad, 0);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_dram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dram_model (
    input  logic                        CLK,
    input  logic                        nRST,
    input  dram_pkg::dram_cmd_t         dram_cmd,
    output logic [dram_pkg::DATA_W-1:0] dram_rdata
);
    import dram_pkg::*;

    logic [DATA_W-1:0]    mem [0:65535];
    logic [NUM_BANKS-1:0] bank_open;
    int                   cmd_cnt;
    int                   act_cnt;
    int                   pre_cnt;
    int                   prea_cnt;
    int                   ref_cnt;
    int                   ref_bad;     // REF seen with a row still open.
    logic                 ref_no_act;  // REF seen and no ACT since.

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {~i[15:0], i[15:0]};
        end
    end

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            bank_open  <= '0;
            cmd_cnt    <= 0;
            act_cnt    <= 0;
            pre_cnt    <= 0;
            prea_cnt   <= 0;
            ref_cnt    <= 0;
            ref_bad    <= 0;
            ref_no_act <= 1'b0;
            dram_rdata <= '0;
        end else begin
            if (dram_cmd.op != NOP) cmd_cnt <= cmd_cnt + 1;
            case (dram_cmd.op)
                ACT: begin
                    act_cnt <= act_cnt + 1;
                    bank_open[dram_cmd.addr.bank] <= 1'b1;
                    ref_no_act <= 1'b0;
                end
                RD: dram_rdata <= mem[dram_cmd.addr];
                WR: mem[dram_cmd.addr] <= dram_cmd.wdata;
                PRE: begin
                    pre_cnt <= pre_cnt + 1;
                    bank_open[dram_cmd.addr.bank] <= 1'b0;
                end
                PREA: begin
                    prea_cnt  <= prea_cnt + 1;
                    bank_open <= '0;
                end
                REF: begin
                    ref_cnt <= ref_cnt + 1;
                    if (bank_open != '0) ref_bad <= ref_bad + 1;
                    bank_open  <= '0;
                    ref_no_act <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dram_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_top (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        PSEL,
    input  logic                        PENABLE,
    input  logic                        PWRITE,
    input  logic [31:0]                 PADDR,
    input  logic [dram_pkg::DATA_W-1:0] PWDATA,
    output logic [dram_pkg::DATA_W-1:0] PRDATA,
    output logic                        PREADY,
    output logic                        PSLVERR,
    output dram_pkg::dram_cmd_t         dram_cmd,
    input  logic [dram_pkg::DATA_W-1:0] dram_rdata
);
    import dram_pkg::*;

    mem_req_t          req;
    row_stat_t         row_stat;
    cmd_state_t        state;
    logic              rf_req;
    logic              delay_done;
    logic              load;
    logic              done;
    logic [DATA_W-1:0] rdata;

    dram_apb_port apb_port_inst (
        .CLK(CLK), .nRST(nRST),
        .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA),
        .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
        .req(req), .done(done), .rdata(rdata)
    );

    dram_cmd_fsm cmd_fsm_inst (
        .CLK(CLK), .nRST(nRST),
        .req(req), .row_stat(row_stat), .rf_req(rf_req),
        .delay_done(delay_done), .dram_rdata(dram_rdata),
        .state(state), .load(load), .dram_cmd(dram_cmd),
        .done(done), .rdata(rdata)
    );

    dram_delay_timer delay_timer_inst (
        .CLK(CLK), .nRST(nRST),
        .state(state), .load(load), .delay_done(delay_done)
    );

    dram_refresh_timer refresh_timer_inst (
        .CLK(CLK), .nRST(nRST),
        .dram_cmd(dram_cmd), .rf_req(rf_req)
    );

    dram_row_table row_table_inst (
        .CLK(CLK), .nRST(nRST),
        .dram_cmd(dram_cmd), .req_addr(req.addr), .row_stat(row_stat)
    );

endmodule

`default_nettype wire

// ==== dram_row_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_row_table (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dram_pkg::dram_cmd_t  dram_cmd,
    input  dram_pkg::dram_addr_t req_addr,
    output dram_pkg::row_stat_t  row_stat
);
    import dram_pkg::*;

    logic [NUM_BANKS-1:0] bank_open;
    logic [ROW_W-1:0]     open_row [NUM_BANKS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            bank_open <= '0;
        end else begin
            case (dram_cmd.op)
                ACT:       bank_open[dram_cmd.addr.bank] <= 1'b1;
                PRE:       bank_open[dram_cmd.addr.bank] <= 1'b0;
                PREA, REF: bank_open <= '0; // All banks closed.
                default:   bank_open <= bank_open;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (dram_cmd.op == ACT) begin
            open_row[dram_cmd.addr.bank] <= dram_cmd.addr.row;
        end
    end

    always_comb begin
        if (!bank_open[req_addr.bank]) begin
            row_stat = MISS;
        end else if (open_row[req_addr.bank] == req_addr.row) begin
            row_stat = HIT;
        end else begin
            row_stat = CONFLICT;
        end
    end

endmodule

`default_nettype wire

// ==== dram_refresh_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_refresh_timer (
    input  logic                CLK,
    input  logic                nRST,
    input  dram_pkg::dram_cmd_t dram_cmd,
    output logic                rf_req
);
    import dram_pkg::*;

    logic [$clog2(REF_INTERVAL)-1:0] interval;
    logic                            wrap;

    assign wrap = (interval == REF_INTERVAL - 1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            interval <= '0;
            rf_req   <= 1'b0;
        end else begin
            interval <= wrap ? '0 : interval + 1'b1; // Free running.
            if (wrap) begin
                rf_req <= 1'b1;
            end else if (dram_cmd.op == REF) begin
                rf_req <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dram_delay_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_delay_timer (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dram_pkg::cmd_state_t state,
    input  logic                 load,
    output logic                 delay_done
);
    import dram_pkg::*;

    logic [DELAY_W-1:0] count;
    logic [DELAY_W-1:0] start;

    // The load cycle counts as the first cycle of the wait.
    always_comb begin
        case (state)
            POWER_UP:   start = DELAY_W'(T_INIT - 2);
            REFRESH:    start = DELAY_W'(T_REF - 2);
            ACTIVATING: start = DELAY_W'(T_ACT - 2);
            READING:    start = DELAY_W'(T_RD - 2);
            WRITING:    start = DELAY_W'(T_WR - 2);
            PRECHARGE:  start = DELAY_W'(T_PRE - 2);
            default:    start = '0;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (load) begin
            count <= start;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Stale zero from the previous wait is masked on load.
    assign delay_done = !load && (count == '0);

endmodule

`default_nettype wire

// ==== dram_cmd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_fsm (
    input  logic                        CLK,
    input  logic                        nRST,
    input  dram_pkg::mem_req_t          req,
    input  dram_pkg::row_stat_t         row_stat,
    input  logic                        rf_req,
    input  logic                        delay_done,
    input  logic [dram_pkg::DATA_W-1:0] dram_rdata,
    output dram_pkg::cmd_state_t        state,
    output logic                        load,
    output dram_pkg::dram_cmd_t         dram_cmd,
    output logic                        done,
    output logic [dram_pkg::DATA_W-1:0] rdata
);
    import dram_pkg::*;

    cmd_state_t        next_state;
    cmd_state_t        prev_state;
    logic              timed;
    logic              pre_all;
    logic [DATA_W-1:0] rd_data;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= POWER_UP;
            prev_state <= IDLE; // So the power-up wait is loaded.
            pre_all    <= 1'b0;
        end else begin
            state      <= next_state;
            prev_state <= state;
            if (state == PRECHARGE && load) begin
                pre_all <= rf_req;
            end
        end
    end

    assign timed = state inside {POWER_UP, REFRESH, ACTIVATING, READING, WRITING, PRECHARGE};
    assign load  = timed && (state != prev_state);

    always_comb begin
        next_state = state;
        case (state)
            POWER_UP: begin
                if (delay_done) next_state = IDLE;
            end
            IDLE: begin
                if (rf_req) begin
                    next_state = PRECHARGE; // PREA first, then REF.
                end else if (req.valid) begin
                    case (row_stat)
                        HIT:      next_state = req.we ? WRITE : READ;
                        CONFLICT: next_state = PRECHARGE;
                        default:  next_state = ACTIVATE;
                    endcase
                end
            end
            REFRESH: begin
                if (delay_done) next_state = IDLE;
            end
            ACTIVATE: next_state = ACTIVATING;
            ACTIVATING: begin
                if (delay_done) begin
                    if (rf_req) next_state = PRECHARGE;
                    else next_state = req.we ? WRITE : READ;
                end
            end
            READ:  next_state = READING;
            WRITE: next_state = WRITING;
            READING, WRITING: begin
                if (delay_done) next_state = rf_req ? PRECHARGE : IDLE;
            end
            PRECHARGE: begin
                // A single-bank PRE goes back through IDLE for the PREA.
                if (delay_done) next_state = (rf_req && pre_all) ? REFRESH : IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        dram_cmd.op    = NOP;
        dram_cmd.addr  = req.addr;
        dram_cmd.wdata = req.wdata;
        case (state)
            ACTIVATE:  dram_cmd.op = ACT;
            READ:      dram_cmd.op = RD;
            WRITE:     dram_cmd.op = WR;
            PRECHARGE: begin
                if (load) dram_cmd.op = rf_req ? PREA : PRE;
            end
            REFRESH: begin
                if (load) dram_cmd.op = REF;
            end
            default: dram_cmd.op = NOP;
        endcase
    end

    assign done = (state == READING || state == WRITING) && delay_done;

    // Model data is stable for the whole of READING.
    always_ff @(posedge CLK) begin
        if (state == READING) begin
            rd_data <= dram_rdata;
        end
    end

    assign rdata = rd_data;

endmodule

`default_nettype wire

// ==== dram_apb_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_apb_port (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        PSEL,
    input  logic                        PENABLE,
    input  logic                        PWRITE,
    input  logic [31:0]                 PADDR,
    input  logic [dram_pkg::DATA_W-1:0] PWDATA,
    output logic [dram_pkg::DATA_W-1:0] PRDATA,
    output logic                        PREADY,
    output logic                        PSLVERR,
    output dram_pkg::mem_req_t          req,
    input  logic                        done,
    input  logic [dram_pkg::DATA_W-1:0] rdata
);
    import dram_pkg::*;

    logic              setup;
    logic              access;
    logic              addr_err;
    logic              accept;
    logic              req_valid;
    logic              req_we;
    dram_addr_t        req_addr;
    logic [DATA_W-1:0] req_wdata;

    assign setup    = PSEL && !PENABLE;
    assign access   = PSEL && PENABLE;
    assign addr_err = |PADDR[31:$bits(dram_addr_t)+2]; // Outside the 18-bit space.
    assign accept   = setup && !addr_err && !req_valid;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_valid <= 1'b0;
        end else if (done) begin
            req_valid <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;
        end
    end

    // Request is taken in the setup phase.
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_we    <= PWRITE;
            req_addr  <= PADDR[$bits(dram_addr_t)+1:2];
            req_wdata <= PWDATA;
        end
    end

    assign req = '{
        valid: req_valid,
        we:    req_we,
        addr:  req_addr,
        wdata: req_wdata
    };

    // Bad addresses finish in the first access cycle.
    assign PREADY  = access && (addr_err || done);
    assign PSLVERR = access && addr_err;
    assign PRDATA  = (access && done && !PWRITE) ? rdata : '0;

endmodule

`default_nettype wire

// ==== dram_pkg.sv ====
`default_nettype none

package dram_pkg;

    localparam int DATA_W    = 32;
    localparam int NUM_BANKS = 4;
    localparam int BANK_W    = 2;
    localparam int ROW_W     = 8;
    localparam int COL_W     = 6;

    // Delays in controller clock cycles.
    localparam int T_INIT       = 20;
    localparam int T_ACT        = 3;
    localparam int T_RD         = 3;
    localparam int T_WR         = 4;
    localparam int T_PRE        = 3;
    localparam int T_REF        = 8;
    localparam int REF_INTERVAL = 200;
    localparam int DELAY_W      = 8;

    typedef enum logic [3:0] {
        POWER_UP   = 4'd0,
        IDLE       = 4'd1,
        REFRESH    = 4'd2,
        ACTIVATE   = 4'd3,
        ACTIVATING = 4'd4,
        READ       = 4'd5,
        READING    = 4'd6,
        WRITE      = 4'd7,
        WRITING    = 4'd8,
        PRECHARGE  = 4'd9
    } cmd_state_t;

    // Code 2'b00 is left unused.
    typedef enum logic [1:0] {
        HIT      = 2'b01,
        MISS     = 2'b10,
        CONFLICT = 2'b11
    } row_stat_t;

    typedef enum logic [2:0] {
        NOP  = 3'd0,
        ACT  = 3'd1,
        RD   = 3'd2,
        WR   = 3'd3,
        PRE  = 3'd4,
        PREA = 3'd5,
        REF  = 3'd6
    } dram_op_t;

    // Word address taken from PADDR[17:2].
    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } dram_addr_t;

    typedef struct packed {
        dram_op_t          op;
        dram_addr_t        addr;
        logic [DATA_W-1:0] wdata;
    } dram_cmd_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        dram_addr_t        addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire
